//--- common/bip_macros.svh
`ifndef BIP_MACROS_SVH
`define BIP_MACROS_SVH

// Instruction word and its two fields
`define BIP_INSTR_W    16
`define BIP_OPCODE_W   5
`define BIP_OPERAND_W  11

// Accumulator and data memory word
`define BIP_DATA_W     16

// Program memory
`define BIP_PMEM_DEPTH 2048
`define BIP_PMEM_AW    11

// Data memory, addressed directly by the operand
`define BIP_DMEM_DEPTH 2048
`define BIP_DMEM_AW    11

`endif

//--- common/bip_pkg.sv
`include "bip_macros.svh"

package bip_pkg;

   typedef logic [`BIP_INSTR_W-1:0]   instr_t;
   typedef logic [`BIP_OPCODE_W-1:0]  opcode_t;
   typedef logic [`BIP_OPERAND_W-1:0] operand_t;
   typedef logic [`BIP_DATA_W-1:0]    data_t;
   typedef logic [`BIP_PMEM_AW-1:0]   pc_t;
   typedef logic [`BIP_DMEM_AW-1:0]   daddr_t;
   typedef logic [1:0]                sela_t;

   // Opcodes, in instruction set order
   localparam opcode_t OP_HALT  = 5'd0;
   localparam opcode_t OP_STORE = 5'd1; // mem[op] <= acc
   localparam opcode_t OP_LOAD  = 5'd2; // acc <= mem[op]
   localparam opcode_t OP_LDI   = 5'd3; // acc <= sext(op)
   localparam opcode_t OP_ADD   = 5'd4;
   localparam opcode_t OP_ADDI  = 5'd5;
   localparam opcode_t OP_SUB   = 5'd6;
   localparam opcode_t OP_SUBI  = 5'd7;

   // Accumulator sources
   localparam sela_t SELA_MEM = 2'b00; // Memory read data
   localparam sela_t SELA_IMM = 2'b01; // Sign extended operand
   localparam sela_t SELA_ALU = 2'b10; // Adder output

   // Second ALU operand
   localparam logic SELB_MEM = 1'b0;
   localparam logic SELB_IMM = 1'b1;

endpackage

//--- common/bip_ctrl_if.sv
`timescale 1ns/1ps

// Decoded control from the control unit to the datapath
interface bip_ctrl_if;

   bip_pkg::sela_t   sel_a;    // Accumulator source
   logic             sel_b;    // ALU operand, 1 picks immediate
   logic             wr_acc;   // Accumulator write enable
   logic             add_nsub; // 1 add, 0 subtract
   bip_pkg::operand_t operand;

   modport ctrl (
      output sel_a, sel_b, wr_acc, add_nsub, operand
   );

   modport dp (
      input sel_a, sel_b, wr_acc, add_nsub, operand
   );

endinterface

//--- common/bip_dmem_if.sv
`timescale 1ns/1ps

interface bip_dmem_if;

   bip_pkg::daddr_t addr;
   bip_pkg::data_t  wdata;
   logic            wr;    // Store strobe
   logic            rd;    // Read strobe
   bip_pkg::data_t  rdata;

   // Strobes come from the control unit through the top
   modport master (
      output addr, wdata,
      input  rdata
   );

   modport mem (
      input  addr, wdata, wr, rd,
      output rdata
   );

endinterface

//--- control/bip_control.sv
`timescale 1ns/1ps
`include "bip_macros.svh"

module bip_control (
   input  logic               i_clk,
   input  logic               i_rst,
   input  bip_pkg::instr_t    i_instruction,
   output bip_pkg::pc_t       o_pc,
   output logic               o_dmem_wr,
   output logic               o_dmem_rd,
   output logic               o_halted,
   bip_ctrl_if.ctrl           ctrl_bus
);

   bip_pkg::pc_t      pc;
   bip_pkg::opcode_t  opcode;
   bip_pkg::operand_t operand;

   logic              pc_en;    // Advance to next instruction
   bip_pkg::sela_t    sel_a;
   logic              sel_b;
   logic              wr_acc;
   logic              add_nsub;
   logic              dmem_wr;
   logic              dmem_rd;

   // Field split
   assign opcode  = i_instruction[`BIP_INSTR_W-1 -: `BIP_OPCODE_W];
   assign operand = i_instruction[`BIP_OPERAND_W-1:0];

   always_comb begin
      pc_en    = 1'b0;           // Halt unless decoded below
      sel_a    = bip_pkg::SELA_MEM;
      sel_b    = bip_pkg::SELB_MEM;
      wr_acc   = 1'b0;
      add_nsub = 1'b0;
      dmem_wr  = 1'b0;
      dmem_rd  = 1'b0;
      case (opcode)
         bip_pkg::OP_STORE: begin
            pc_en   = 1'b1;
            sel_a   = 2'b11;     // Don't care, acc not written
            dmem_wr = 1'b1;
         end
         bip_pkg::OP_LOAD: begin
            pc_en   = 1'b1;
            wr_acc  = 1'b1;
            dmem_rd = 1'b1;
         end
         bip_pkg::OP_LDI: begin
            pc_en  = 1'b1;
            sel_a  = bip_pkg::SELA_IMM;
            wr_acc = 1'b1;
         end
         bip_pkg::OP_ADD: begin
            pc_en    = 1'b1;
            sel_a    = bip_pkg::SELA_ALU;
            wr_acc   = 1'b1;
            add_nsub = 1'b1;
            dmem_rd  = 1'b1;
         end
         bip_pkg::OP_ADDI: begin
            pc_en    = 1'b1;
            sel_a    = bip_pkg::SELA_ALU;
            sel_b    = bip_pkg::SELB_IMM;
            wr_acc   = 1'b1;
            add_nsub = 1'b1;
         end
         bip_pkg::OP_SUB: begin
            pc_en   = 1'b1;
            sel_a   = bip_pkg::SELA_ALU;
            wr_acc  = 1'b1;
            dmem_rd = 1'b1;
         end
         bip_pkg::OP_SUBI: begin
            pc_en  = 1'b1;
            sel_a  = bip_pkg::SELA_ALU;
            sel_b  = bip_pkg::SELB_IMM;
            wr_acc = 1'b1;
         end
         default: ;              // Halt and unknown opcodes
      endcase
   end

   // Program counter, holds on halt
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc <= '0;
      end else if (pc_en) begin
         pc <= pc + 1'b1;
      end
   end

   assign o_pc      = pc;
   assign o_halted  = ~pc_en;
   assign o_dmem_wr = dmem_wr & ~i_rst; // No strobes while in reset
   assign o_dmem_rd = dmem_rd & ~i_rst;

   assign ctrl_bus.sel_a    = sel_a;
   assign ctrl_bus.sel_b    = sel_b;
   assign ctrl_bus.wr_acc   = wr_acc;
   assign ctrl_bus.add_nsub = add_nsub;
   assign ctrl_bus.operand  = operand;

endmodule

//--- datapath/bip_datapath.sv
`timescale 1ns/1ps
`include "bip_macros.svh"

module bip_datapath (
   input  logic           i_clk,
   input  logic           i_rst,
   output bip_pkg::data_t o_acc,
   bip_ctrl_if.dp         ctrl_bus,
   bip_dmem_if.master     dmem
);

   localparam int EXT_W = `BIP_DATA_W - `BIP_OPERAND_W;

   bip_pkg::data_t acc;
   bip_pkg::data_t acc_next;
   bip_pkg::data_t imm;        // Sign extended operand
   bip_pkg::data_t alu_b;
   bip_pkg::data_t alu_out;

   assign imm = {{EXT_W{ctrl_bus.operand[`BIP_OPERAND_W-1]}}, ctrl_bus.operand};

   // Second operand mux
   assign alu_b = (ctrl_bus.sel_b == bip_pkg::SELB_IMM) ? imm : dmem.rdata;

   always_comb begin
      if (ctrl_bus.add_nsub) begin
         alu_out = acc + alu_b;
      end else begin
         alu_out = acc - alu_b;  // Wraps at word width
      end
   end

   always_comb begin
      case (ctrl_bus.sel_a)
         bip_pkg::SELA_MEM: acc_next = dmem.rdata;
         bip_pkg::SELA_IMM: acc_next = imm;
         bip_pkg::SELA_ALU: acc_next = alu_out;
         default:           acc_next = acc;
      endcase
   end

   // Accumulator
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         acc <= '0;
      end else if (ctrl_bus.wr_acc) begin
         acc <= acc_next;
      end
   end

   // Operand is the direct data address
   assign dmem.addr  = bip_pkg::daddr_t'(ctrl_bus.operand);
   assign dmem.wdata = acc;

   assign o_acc = acc;

endmodule

//--- design/bip_prog_mem.sv
`timescale 1ns/1ps
`include "bip_macros.svh"

module bip_prog_mem (
   input  logic            i_clk,
   input  logic            i_we,
   input  bip_pkg::pc_t    i_waddr,
   input  bip_pkg::instr_t i_wdata,
   input  bip_pkg::pc_t    i_raddr,
   output bip_pkg::instr_t o_rdata
);

   bip_pkg::instr_t mem [`BIP_PMEM_DEPTH];

   // Load port, loader uses it while the core is held in reset
   always_ff @(posedge i_clk) begin
      if (i_we) begin
         mem[i_waddr] <= i_wdata;
      end
   end

   // Fetch is combinational
   assign o_rdata = mem[i_raddr];

endmodule

//--- design/bip_data_mem.sv
`timescale 1ns/1ps
`include "bip_macros.svh"

module bip_data_mem (
   input  logic    i_clk,
   input  logic    i_rst,
   bip_dmem_if.mem dmem
);

   bip_pkg::data_t mem [`BIP_DMEM_DEPTH];

   // Unwritten words read as zero in simulation
   initial begin
      for (int i = 0; i < `BIP_DMEM_DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (dmem.wr && !i_rst) begin
         mem[dmem.addr] <= dmem.wdata; // Store
      end
   end

   assign dmem.rdata = dmem.rd ? mem[dmem.addr] : '0;

endmodule

//--- design/bip_top.sv
`timescale 1ns/1ps

module bip_top (
   input  logic            i_clk,
   input  logic            i_rst,
   input  logic            i_prog_we,
   input  bip_pkg::pc_t    i_prog_addr,
   input  bip_pkg::instr_t i_prog_data,
   output bip_pkg::pc_t    o_pc,
   output bip_pkg::data_t  o_acc,
   output logic            o_halted
);

   bip_pkg::pc_t    pc;
   bip_pkg::instr_t instruction;
   logic            dmem_wr;
   logic            dmem_rd;

   bip_ctrl_if ctrl_bus ();
   bip_dmem_if dmem_bus ();

   // Strobes join the datapath's address and data here
   assign dmem_bus.wr = dmem_wr;
   assign dmem_bus.rd = dmem_rd;

   bip_prog_mem u_prog_mem (
      .i_clk   (i_clk),
      .i_we    (i_prog_we),
      .i_waddr (i_prog_addr),
      .i_wdata (i_prog_data),
      .i_raddr (pc),
      .o_rdata (instruction)
   );

   bip_control u_control (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_instruction (instruction),
      .o_pc          (pc),
      .o_dmem_wr     (dmem_wr),
      .o_dmem_rd     (dmem_rd),
      .o_halted      (o_halted),
      .ctrl_bus      (ctrl_bus.ctrl)
   );

   bip_datapath u_datapath (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .o_acc    (o_acc),
      .ctrl_bus (ctrl_bus.dp),
      .dmem     (dmem_bus.master)
   );

   bip_data_mem u_data_mem (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .dmem  (dmem_bus.mem)
   );

   assign o_pc = pc;

endmodule

//--- tests/bip_checker.sv
`timescale 1ns/1ps

module bip_checker (
   input logic           i_clk,
   input logic           i_rst,
   input bip_pkg::pc_t   i_pc,
   input bip_pkg::data_t i_acc,
   input logic           i_halted
);

   int fail_count = 0;

   // Any executed instruction that is not a halt moves to the next word
   property p_pc_advance;
      @(posedge i_clk) disable iff (i_rst)
         !i_halted |=> i_pc == bip_pkg::pc_t'($past(i_pc) + 1'b1);
   endproperty

   property p_halt_holds;
      @(posedge i_clk) disable iff (i_rst)
         i_halted |=> (i_pc == $past(i_pc)) && (i_acc == $past(i_acc));
   endproperty

   // First cycle out of reset starts at address zero
   property p_start_at_zero;
      @(posedge i_clk) $fell(i_rst) |-> i_pc == '0;
   endproperty

   a_pc_advance: assert property (p_pc_advance) else begin
      $error("pc did not advance");
      fail_count++;
   end

   a_halt_holds: assert property (p_halt_holds) else begin
      $error("state moved while halted");
      fail_count++;
   end

   a_start_zero: assert property (p_start_at_zero) else begin
      $error("pc not zero after reset");
      fail_count++;
   end

endmodule

bind bip_top bip_checker u_checker (
   .i_clk    (i_clk),
   .i_rst    (i_rst),
   .i_pc     (o_pc),
   .i_acc    (o_acc),
   .i_halted (o_halted)
);

//--- tests/bip_tb.sv
`timescale 1ns/1ps
`include "bip_macros.svh"

module bip_tb;

   logic            i_clk;
   logic            i_rst;
   logic            i_prog_we;
   bip_pkg::pc_t    i_prog_addr;
   bip_pkg::instr_t i_prog_data;
   bip_pkg::pc_t    o_pc;
   bip_pkg::data_t  o_acc;
   logic            o_halted;

   bip_pkg::instr_t prog_img  [`BIP_PMEM_DEPTH]; // Mirror of program memory
   bip_pkg::data_t  model_mem [`BIP_DMEM_DEPTH]; // Survives reset like the DUT
   bip_pkg::instr_t prog_q [$];
   bip_pkg::pc_t    model_pc;
   bip_pkg::data_t  model_acc;
   logic            rst_q;                      // Reset seen at the last rising edge

   bip_top UUT (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_prog_we   (i_prog_we),
      .i_prog_addr (i_prog_addr),
      .i_prog_data (i_prog_data),
      .o_pc        (o_pc),
      .o_acc       (o_acc),
      .o_halted    (o_halted)
   );

   always #5 i_clk = ~i_clk;

   task automatic stop_with_failure();
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_pc(input string name, input bip_pkg::pc_t got, input bip_pkg::pc_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_acc(input string name, input bip_pkg::data_t got,
                            input bip_pkg::data_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
         stop_with_failure();
      end
   endtask

   function automatic bip_pkg::instr_t make_instr(input bip_pkg::opcode_t op, input int value);
      return {op, bip_pkg::operand_t'(value)};
   endfunction

   // Halt and any opcode past the last defined one stop the core
   function automatic logic halts(input bip_pkg::instr_t instr);
      bip_pkg::opcode_t op;
      op = instr[`BIP_INSTR_W-1 -: `BIP_OPCODE_W];
      return (op == bip_pkg::OP_HALT) || (op > bip_pkg::OP_SUBI);
   endfunction

   function automatic void step_ref(inout bip_pkg::pc_t pc, inout bip_pkg::data_t acc,
                                    input bip_pkg::instr_t instr);
      bip_pkg::opcode_t  op;
      bip_pkg::operand_t opnd;
      bip_pkg::data_t    imm;
      op   = instr[`BIP_INSTR_W-1 -: `BIP_OPCODE_W];
      opnd = instr[`BIP_OPERAND_W-1:0];
      imm  = {{(`BIP_DATA_W-`BIP_OPERAND_W){opnd[`BIP_OPERAND_W-1]}}, opnd};
      if (!halts(instr)) begin
         case (op)
            bip_pkg::OP_STORE: model_mem[opnd] = acc;
            bip_pkg::OP_LOAD:  acc = model_mem[opnd];
            bip_pkg::OP_LDI:   acc = imm;
            bip_pkg::OP_ADD:   acc = acc + model_mem[opnd];
            bip_pkg::OP_ADDI:  acc = acc + imm;
            bip_pkg::OP_SUB:   acc = acc - model_mem[opnd];
            default:           acc = acc - imm; // Subtract immediate
         endcase
         pc = pc + 1'b1;
      end
   endfunction

   always @(posedge i_clk) rst_q <= i_rst;

   // Compare outputs with the model once the rising edge has settled
   always @(negedge i_clk) begin
      if (UUT.u_checker.fail_count != 0) begin
         $display("A bound assertion failed before %0t", $time);
         stop_with_failure();
      end
      if (rst_q) begin
         model_pc  = '0;
         model_acc = '0;
         check_pc("o_pc", o_pc, model_pc);
         check_acc("o_acc", o_acc, model_acc);
      end else begin
         step_ref(model_pc, model_acc, prog_img[model_pc]);
         check_pc("o_pc", o_pc, model_pc);
         check_acc("o_acc", o_acc, model_acc);
         check_flag("o_halted", o_halted, halts(prog_img[model_pc]));
      end
   end

   // Loads prog_q while the core is held in reset, then releases it
   task automatic load_program();
      @(negedge i_clk);
      i_rst = 1'b1;
      for (int i = 0; i < prog_q.size(); i++) begin
         @(negedge i_clk);
         i_prog_we   = 1'b1;
         i_prog_addr = bip_pkg::pc_t'(i);
         i_prog_data = prog_q[i];
         prog_img[i] = prog_q[i];
      end
      @(negedge i_clk);
      i_prog_we = 1'b0;
      repeat (3) @(negedge i_clk);
      i_rst = 1'b0;
   endtask

   task automatic wait_halt(input int limit);
      int n;
      n = 0;
      while (o_halted !== 1'b1 && n < limit) begin
         @(negedge i_clk);
         n++;
      end
      if (o_halted !== 1'b1) begin
         $display("Timeout: o_halted did not rise within %0d cycles", limit);
         stop_with_failure();
      end
   endtask

   task automatic hold_check(input bip_pkg::pc_t exp_pc, input bip_pkg::data_t exp_acc);
      repeat (20) begin
         @(negedge i_clk);
         check_pc("o_pc", o_pc, exp_pc);
         check_acc("o_acc", o_acc, exp_acc);
         check_flag("o_halted", o_halted, 1'b1);
      end
   endtask

   task automatic build_random(input int len);
      bip_pkg::opcode_t op;
      prog_q.delete();
      for (int i = 0; i < len; i++) begin
         op = bip_pkg::opcode_t'($urandom_range(1, 7));
         if (op == bip_pkg::OP_LDI || op == bip_pkg::OP_ADDI || op == bip_pkg::OP_SUBI)
            prog_q.push_back(make_instr(op, $urandom_range(0, 2047)));
         else
            prog_q.push_back(make_instr(op, $urandom_range(0, 15))); // Reused addresses
      end
      prog_q.push_back(make_instr(bip_pkg::OP_HALT, 0));
   endtask

   initial begin
      i_clk = 1'b0;
      i_rst = 1'b1;
      i_prog_we = 1'b0;
      i_prog_addr = '0;
      i_prog_data = '0;
      rst_q = 1'b1;
      model_pc = '0;
      model_acc = '0;
      for (int i = 0; i < `BIP_DMEM_DEPTH; i++) model_mem[i] = '0;
      void'($urandom(32'h039235f9));

      // Immediates with both signs and wrap at 16 bits
      prog_q = '{make_instr(bip_pkg::OP_LDI, 5), make_instr(bip_pkg::OP_ADDI, 100),
                 make_instr(bip_pkg::OP_ADDI, -3), make_instr(bip_pkg::OP_SUBI, 50),
                 make_instr(bip_pkg::OP_SUBI, -1024), make_instr(bip_pkg::OP_LDI, -1),
                 make_instr(bip_pkg::OP_ADDI, 1), make_instr(bip_pkg::OP_SUBI, 1),
                 make_instr(bip_pkg::OP_ADDI, -1024), make_instr(bip_pkg::OP_HALT, 0)};
      load_program();
      check_pc("o_pc", o_pc, '0);
      check_acc("o_acc", o_acc, '0);
      wait_halt(30);
      hold_check(9, 16'hfbff);

      // Stores, loads and memory arithmetic, address 100 never written
      prog_q = '{make_instr(bip_pkg::OP_LDI, 7), make_instr(bip_pkg::OP_STORE, 3),
                 make_instr(bip_pkg::OP_LDI, -2), make_instr(bip_pkg::OP_STORE, 4),
                 make_instr(bip_pkg::OP_LOAD, 3), make_instr(bip_pkg::OP_ADD, 4),
                 make_instr(bip_pkg::OP_SUB, 3), make_instr(bip_pkg::OP_ADD, 100),
                 make_instr(bip_pkg::OP_STORE, 5), make_instr(bip_pkg::OP_LOAD, 5),
                 make_instr(bip_pkg::OP_SUB, 4), make_instr(bip_pkg::OP_ADD, 3),
                 make_instr(bip_pkg::OP_HALT, 0)};
      load_program();
      wait_halt(30);
      hold_check(12, 16'h0007);

      // Unknown opcodes stop the core like halt
      prog_q = '{make_instr(bip_pkg::OP_LDI, 9), make_instr(bip_pkg::OP_ADDI, 1),
                 make_instr(5'd13, 'h55), make_instr(bip_pkg::OP_LDI, 1)};
      load_program();
      wait_halt(30);
      hold_check(2, 16'h000a);
      prog_q = '{make_instr(bip_pkg::OP_LDI, -5), make_instr(5'd31, 0)};
      load_program();
      wait_halt(30);
      hold_check(1, 16'hfffb);

      for (int run = 0; run < 3; run++) begin
         build_random(40);
         load_program();
         wait_halt(60);
         @(negedge i_clk);           // Model has stepped onto the halt by now
         hold_check(model_pc, model_acc);
      end

      if (UUT.u_checker.fail_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- list.f
+incdir+common
common/bip_pkg.sv
common/bip_ctrl_if.sv
common/bip_dmem_if.sv
control/bip_control.sv
datapath/bip_datapath.sv
design/bip_prog_mem.sv
design/bip_data_mem.sv
design/bip_top.sv
tests/bip_checker.sv
tests/bip_tb.sv
